/* hw/mcu_sram_pkg.sv */
/*
 * MCU SRAM controller package
 * Sizes, widths and the packed structs that carry requests, responses
 * and status between the fabric, the controller stages and the SRAM.
 * Also holds the data bit placement of the SEC-DED code.
 */

package mcu_sram_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // SRAM geometry

    localparam int mcu_sram_size_kb     = 16;
    localparam int mcu_sram_size_bytes  = mcu_sram_size_kb * 1024;
    localparam int mcu_sram_data_w      = 32;
    localparam int mcu_sram_ecc_w       = 7;
    localparam int mcu_sram_depth       = mcu_sram_size_bytes / (mcu_sram_data_w / 8);
    localparam int mcu_sram_addr_w      = $clog2(mcu_sram_depth);
    // Byte address bits needed to reach every location
    localparam int mcu_sram_byte_addr_w = $clog2(mcu_sram_size_bytes);
    localparam int mcu_sram_strb_w      = mcu_sram_data_w / 8;

    // Exec region is sized by firmware in 4 KB pages, 0 meaning one page
    localparam int exec_region_page_shift = 12;
    localparam int exec_region_size_w     = 16;
    // (0xffff + 1) << 12 sets bit 28, so 29 bits hold the end without wrap
    localparam int exec_region_calc_w     = 29;

    ////////////////////////////////////////////////////////////////////////////
    // Packed structs

    // Stored word, data plus check bits
    typedef struct packed {
        logic [mcu_sram_data_w-1:0] data;
        logic [mcu_sram_ecc_w-1:0]  ecc;
    } mcu_sram_word_t;

    // Fabric request, held steady by the requester while hold is high
    typedef struct packed {
        logic [31:0]                addr;
        logic                       write;
        logic [mcu_sram_strb_w-1:0] wstrb;
        logic [mcu_sram_data_w-1:0] wdata;
    } cif_req_t;

    typedef struct packed {
        logic                       hold;
        logic                       error;
        logic [mcu_sram_data_w-1:0] rdata;
    } cif_resp_t;

    // One bit per requesting agent
    typedef struct packed {
        logic debug;
        logic mcu_lsu;
        logic mcu_ifu;
        logic cptra;
    } agent_t;

    typedef struct packed {
        logic                       cs;
        logic                       we;
        logic [mcu_sram_addr_w-1:0] addr;
        mcu_sram_word_t             wdata;
    } sram_req_t;

    // Read data, valid one cycle after a read
    typedef struct packed {
        mcu_sram_word_t rdata;
    } sram_resp_t;

    // Filter verdict, both low when dv is low
    typedef struct packed {
        logic grant;
        logic refuse;
    } grant_t;

    typedef struct packed {
        logic single;
        logic double;
    } ecc_status_t;

    ////////////////////////////////////////////////////////////////////////////
    // SEC-DED bit placement

    // Codeword position of data bit idx
    // Positions are 1-based, powers of two are left for the check bits
    function automatic int unsigned ecc_data_pos(input int unsigned idx);
        int unsigned cnt;
        int unsigned pos;
        cnt = 0;
        pos = 0;
        for (int unsigned p = 3; p <= 38; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) begin
                    pos = p;
                end
                cnt++;
            end
        end
        return pos;
    endfunction

endpackage

/* hw/mcu_sram_ecc_encode.sv */
/*
 * SEC-DED encoder
 * Extended Hamming code over 32 data bits. Six check bits cover the
 * data positions and the seventh gives overall parity.
 */

`timescale 1ns/1ps

module mcu_sram_ecc_encode (
    input  logic [mcu_sram_pkg::mcu_sram_data_w-1:0] data,
    output mcu_sram_pkg::mcu_sram_word_t             word
);

    import mcu_sram_pkg::*;

    logic [mcu_sram_ecc_w-2:0] hamming;

    // Each set data bit folds its codeword position into the checks
    always_comb begin
        hamming = '0;
        for (int unsigned i = 0; i < mcu_sram_data_w; i++) begin
            if (data[i]) begin
                hamming = hamming ^ (mcu_sram_ecc_w - 1)'(ecc_data_pos(i));
            end
        end
    end

    assign word.data = data;
    // Top bit makes the whole codeword even
    assign word.ecc  = {^{data, hamming}, hamming};

endmodule

/* hw/mcu_sram_ecc_decode.sv */
/*
 * SEC-DED decoder
 * Forms the syndrome of a stored word, corrects a single data bit
 * and flags single and double errors while enabled.
 */

`timescale 1ns/1ps

module mcu_sram_ecc_decode (
    input  logic                                     en,
    input  mcu_sram_pkg::mcu_sram_word_t             word,
    output logic [mcu_sram_pkg::mcu_sram_data_w-1:0] data,
    output mcu_sram_pkg::ecc_status_t                status
);

    import mcu_sram_pkg::*;

    logic [mcu_sram_ecc_w-2:0] syndrome;
    // High when an odd number of bits flipped
    logic                      parity_err;

    ////////////////////////////////////////////////////////////////////////////
    // Syndrome

    // Stored checks against the checks of the data as read
    always_comb begin
        syndrome = word.ecc[mcu_sram_ecc_w-2:0];
        for (int unsigned i = 0; i < mcu_sram_data_w; i++) begin
            if (word.data[i]) begin
                syndrome = syndrome ^ (mcu_sram_ecc_w - 1)'(ecc_data_pos(i));
            end
        end
    end

    assign parity_err = ^{word.data, word.ecc};

    ////////////////////////////////////////////////////////////////////////////
    // Correction

    // Flip the data bit the syndrome points at
    // A hit on a check position leaves the data alone
    always_comb begin
        data = word.data;
        if (parity_err) begin
            for (int unsigned i = 0; i < mcu_sram_data_w; i++) begin
                if (syndrome == (mcu_sram_ecc_w - 1)'(ecc_data_pos(i))) begin
                    data[i] = ~word.data[i];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Flags

    // Odd flip count is one error, correctable
    assign status.single = en & parity_err;
    // Even count with a nonzero syndrome is two errors
    assign status.double = en & ~parity_err & (|syndrome);

endmodule

/* hw/mcu_sram_region_filter.sv */
/*
 * MCU SRAM region filter
 * Maps the request address to the exec or the prot region and grants
 * or refuses the access by requesting agent and exec ownership.
 */

`timescale 1ns/1ps

module mcu_sram_region_filter (
    input  logic                                             clk,
    input  logic                                             rst_b,
    input  logic                                             dv,
    input  logic [mcu_sram_pkg::mcu_sram_byte_addr_w-1:0]    addr,
    input  mcu_sram_pkg::agent_t                             agent,
    input  logic [mcu_sram_pkg::exec_region_size_w-1:0]      fw_sram_exec_region_size,
    input  logic                                             mcu_sram_fw_exec_region_lock,
    input  logic                                             mcu_rst_b,
    output mcu_sram_pkg::grant_t                             grant
);

    import mcu_sram_pkg::*;

    logic [exec_region_calc_w-1:0]   exec_region_size_bytes;
    logic [exec_region_calc_w-1:0]   exec_region_end_calc;
    logic                            exec_region_overflow;
    logic [mcu_sram_byte_addr_w-1:0] exec_region_end;
    logic                            exec_region_match;
    // Set while the MCU owns the exec region
    logic                            mcu_access;
    logic                            allowed;

    ////////////////////////////////////////////////////////////////////////////
    // Region mapping

    // Exec region starts at 0, size in pages plus one
    assign exec_region_size_bytes =
        (exec_region_calc_w'(fw_sram_exec_region_size) + 1'b1) << exec_region_page_shift;
    assign exec_region_end_calc = exec_region_size_bytes - 1'b1;

    // Any bit above the SRAM scope means the region covers the whole SRAM
    assign exec_region_overflow = |exec_region_end_calc[exec_region_calc_w-1:mcu_sram_byte_addr_w];
    assign exec_region_end = exec_region_overflow ?
                             mcu_sram_byte_addr_w'(mcu_sram_size_bytes - 1) :
                             exec_region_end_calc[mcu_sram_byte_addr_w-1:0];

    assign exec_region_match = (addr <= exec_region_end);

    ////////////////////////////////////////////////////////////////////////////
    // Exec ownership

    // Lock hands the region to the MCU at once
    // Caliptra gets it back only once the MCU has been held in reset
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            mcu_access <= 1'b0;
        end else if (mcu_sram_fw_exec_region_lock) begin
            mcu_access <= 1'b1;
        end else if (!mcu_rst_b) begin
            mcu_access <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Agent rules

    always_comb begin
        if (!exec_region_match) begin
            // Prot region, MCU data side and debug only
            allowed = agent.mcu_lsu | agent.debug;
        end else if (mcu_access) begin
            allowed = agent.mcu_lsu | agent.mcu_ifu | agent.debug;
        end else begin
            allowed = agent.cptra | agent.debug;
        end
    end

    // Verdict only while a request is present
    assign grant.grant  = dv & allowed;
    assign grant.refuse = dv & ~allowed;

    a_grant_mutex: assert property (@(posedge clk) disable iff (!rst_b)
        !(grant.grant && grant.refuse));

endmodule

/* hw/mcu_sram_access_seq.sv */
/*
 * MCU SRAM access sequencer
 * Turns a granted fabric request into one or two SRAM cycles.
 * Reads and partial writes take two cycles, full writes one.
 * Partial writes merge new bytes over the corrected read word.
 */

`timescale 1ns/1ps

module mcu_sram_access_seq (
    input  logic                                    clk,
    input  logic                                    rst_b,
    input  mcu_sram_pkg::cif_req_t                  req,
    input  mcu_sram_pkg::grant_t                    grant,
    input  logic [mcu_sram_pkg::mcu_sram_data_w-1:0] rdata_cor,
    input  logic                                    double_err,
    output mcu_sram_pkg::sram_req_t                 sram_req,
    output logic                                    second_cycle,
    output logic                                    read_req
);

    import mcu_sram_pkg::*;

    logic                       full_strb;
    logic                       rd_req;
    logic                       wr_full_req;
    logic                       rmw_req;
    logic                       write_req;
    logic [mcu_sram_data_w-1:0] merged_data;
    logic [mcu_sram_data_w-1:0] wdata_plain;
    mcu_sram_word_t             wdata_word;

    ////////////////////////////////////////////////////////////////////////////
    // Request classes

    assign full_strb   = &req.wstrb;
    assign rd_req      = grant.grant & ~req.write;
    assign wr_full_req = grant.grant & req.write & full_strb;
    assign rmw_req     = grant.grant & req.write & ~full_strb;

    // Second cycle follows every read and every RMW read phase
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            second_cycle <= 1'b0;
        end else begin
            second_cycle <= (rd_req | rmw_req) & ~second_cycle;
        end
    end

    // SRAM read in the first cycle of a read or an RMW
    assign read_req = (rd_req | rmw_req) & ~second_cycle;

    // RMW write phase is dropped when the old word is not trustworthy
    assign write_req = (wr_full_req & ~second_cycle) |
                       (rmw_req & second_cycle & ~double_err);

    ////////////////////////////////////////////////////////////////////////////
    // Write data

    // Strobed bytes from the request, the rest from the SRAM
    always_comb begin
        for (int i = 0; i < mcu_sram_strb_w; i++) begin
            merged_data[i*8 +: 8] = req.wstrb[i] ? req.wdata[i*8 +: 8] : rdata_cor[i*8 +: 8];
        end
    end

    // Data stays zero outside a write
    always_comb begin
        wdata_plain = '0;
        if (write_req) begin
            wdata_plain = rmw_req ? merged_data : req.wdata;
        end
    end

    mcu_sram_ecc_encode i_ecc_encode (
        .data (wdata_plain),
        .word (wdata_word)
    );

    ////////////////////////////////////////////////////////////////////////////
    // SRAM port

    assign sram_req.cs    = read_req | write_req;
    assign sram_req.we    = write_req;
    // Word address, zero while idle
    assign sram_req.addr  = sram_req.cs ? req.addr[mcu_sram_byte_addr_w-1:2] : '0;
    assign sram_req.wdata = wdata_word;

    // A partial write reaches the SRAM only after its read
    a_no_partial_first: assert property (@(posedge clk) disable iff (!rst_b)
        (sram_req.we && !second_cycle) |-> full_strb);

endmodule

/* hw/mcu_sram_read_resp.sv */
/*
 * MCU SRAM read response
 * Builds hold, error and read data for the fabric and decodes the
 * SRAM word in the data phase.
 */

`timescale 1ns/1ps

module mcu_sram_read_resp (
    input  mcu_sram_pkg::grant_t                     grant,
    input  logic                                     second_cycle,
    input  logic                                     read_req,
    input  logic                                     is_read,
    input  mcu_sram_pkg::sram_resp_t                 sram_resp,
    output mcu_sram_pkg::cif_resp_t                  resp,
    output mcu_sram_pkg::ecc_status_t                status,
    output logic [mcu_sram_pkg::mcu_sram_data_w-1:0] rdata_cor
);

    import mcu_sram_pkg::*;

    ecc_status_t ecc_status;

    // SRAM data is only valid in the cycle after a read
    mcu_sram_ecc_decode i_ecc_decode (
        .en     (second_cycle),
        .word   (sram_resp.rdata),
        .data   (rdata_cor),
        .status (ecc_status)
    );

    assign status = ecc_status;

    // Stall the fabric for the cycle the SRAM needs to return data
    assign resp.hold  = read_req;

    // Refusals land in the first cycle, ECC failures in the data phase
    assign resp.error = grant.refuse | ecc_status.double;

    // RMW read data stays internal
    assign resp.rdata = (grant.grant & is_read & second_cycle) ? rdata_cor : '0;

endmodule

/* hw/mcu_sram_ctrl.sv */
/*
 * MCU SRAM controller
 * Filters fabric requests by region and agent, sequences reads,
 * writes and read-modify-writes to an ECC protected SRAM and returns
 * the fabric response and the ECC status.
 */

`timescale 1ns/1ps

module mcu_sram_ctrl (
    input  logic                                        clk,
    input  logic                                        rst_b,

    // Fabric port
    input  logic                                        dv,
    input  mcu_sram_pkg::cif_req_t                      cif_req,
    output mcu_sram_pkg::cif_resp_t                     cif_resp,

    // Agent and firmware controls
    input  mcu_sram_pkg::agent_t                        agent,
    input  logic [mcu_sram_pkg::exec_region_size_w-1:0] fw_sram_exec_region_size,
    input  logic                                        mcu_sram_fw_exec_region_lock,
    input  logic                                        mcu_rst_b,

    // SRAM port
    output mcu_sram_pkg::sram_req_t                     sram_req,
    input  mcu_sram_pkg::sram_resp_t                    sram_resp,

    output logic                                        sram_single_ecc_error,
    output logic                                        sram_double_ecc_error
);

    import mcu_sram_pkg::*;

    grant_t                     grant;
    logic                       second_cycle;
    logic                       read_req;
    logic [mcu_sram_data_w-1:0] rdata_cor;
    ecc_status_t                ecc_status;

    ////////////////////////////////////////////////////////////////////////////
    // Decode

    mcu_sram_region_filter i_region_filter (
        .clk                          (clk),
        .rst_b                        (rst_b),
        .dv                           (dv),
        .addr                         (cif_req.addr[mcu_sram_byte_addr_w-1:0]),
        .agent                        (agent),
        .fw_sram_exec_region_size     (fw_sram_exec_region_size),
        .mcu_sram_fw_exec_region_lock (mcu_sram_fw_exec_region_lock),
        .mcu_rst_b                    (mcu_rst_b),
        .grant                        (grant)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute

    mcu_sram_access_seq i_access_seq (
        .clk          (clk),
        .rst_b        (rst_b),
        .req          (cif_req),
        .grant        (grant),
        .rdata_cor    (rdata_cor),
        .double_err   (ecc_status.double),
        .sram_req     (sram_req),
        .second_cycle (second_cycle),
        .read_req     (read_req)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Result

    mcu_sram_read_resp i_read_resp (
        .grant        (grant),
        .second_cycle (second_cycle),
        .read_req     (read_req),
        .is_read      (!cif_req.write),
        .sram_resp    (sram_resp),
        .resp         (cif_resp),
        .status       (ecc_status),
        .rdata_cor    (rdata_cor)
    );

    assign sram_single_ecc_error = ecc_status.single;
    assign sram_double_ecc_error = ecc_status.double;

    // Refused requests never touch the SRAM
    a_refuse_no_sram: assert property (@(posedge clk) disable iff (!rst_b)
        grant.refuse |-> !sram_req.cs);

endmodule

/* dv/tb_mcu_sram_ctrl.sv */
/*
 * MCU SRAM controller testbench
 * Random fabric traffic against a shadow memory and region model,
 * with an SRAM model that can flip stored bits on the read path.
 */

`timescale 1ns/1ps

module tb_mcu_sram_ctrl;

    import mcu_sram_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 16;
    localparam int n_pairs      = 64;
    localparam int n_random     = 100;
    localparam int n_ecc        = 16;
    // Request slots over all phases, with slack for probes and control changes
    localparam int total_requests = mcu_sram_depth + 4 * n_pairs + 4 * n_random + 6 * n_ecc + 32;

    logic                          clk;
    logic                          rst_b;
    logic                          dv;
    cif_req_t                      cif_req;
    cif_resp_t                     cif_resp;
    agent_t                        agent;
    logic [exec_region_size_w-1:0] fw_size;
    logic                          lock;
    logic                          mcu_rst_b;
    sram_req_t                     sram_req;
    sram_resp_t                    sram_resp;
    logic                          single_err;
    logic                          double_err;

    mcu_sram_word_t sram_mem [mcu_sram_depth];
    // Bits inverted on the way out of the SRAM
    logic [38:0]    flip_mask;
    logic [31:0]    shadow [mcu_sram_depth];
    logic           mcu_owner;
    logic [31:0]    lfsr_state;
    int             checks;
    int             value_errors;
    int             other_errors;

    always #(clk_period / 2) clk = ~clk;

    mcu_sram_ctrl i_mcu_sram_ctrl (
        .clk                          (clk),
        .rst_b                        (rst_b),
        .dv                           (dv),
        .cif_req                      (cif_req),
        .cif_resp                     (cif_resp),
        .agent                        (agent),
        .fw_sram_exec_region_size     (fw_size),
        .mcu_sram_fw_exec_region_lock (lock),
        .mcu_rst_b                    (mcu_rst_b),
        .sram_req                     (sram_req),
        .sram_resp                    (sram_resp),
        .sram_single_ecc_error        (single_err),
        .sram_double_ecc_error        (double_err)
    );

    ////////////////////////////////////////////////////////////////////////////
    // SRAM model and ownership model

    // Read data one cycle after the read, stored word itself stays clean
    always @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            sram_resp <= '0;
        end else if (sram_req.cs && sram_req.we) begin
            sram_mem[sram_req.addr] <= sram_req.wdata;
        end else if (sram_req.cs) begin
            sram_resp.rdata <= sram_mem[sram_req.addr] ^ flip_mask;
        end
    end

    // Lock gives the exec region to the MCU, MCU reset hands it back
    always @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            mcu_owner <= 1'b0;
        end else if (lock) begin
            mcu_owner <= 1'b1;
        end else if (!mcu_rst_b) begin
            mcu_owner <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // One or two distinct codeword bits
    function automatic logic [38:0] make_flip(input int n);
        int          a;
        int          b;
        logic [38:0] m;
        m = '0;
        a = int'(rand_bits(6) % 39);
        b = (a + 1 + int'(rand_bits(6) % 38)) % 39;
        if (n >= 1) m[a] = 1'b1;
        if (n >= 2) m[b] = 1'b1;
        return m;
    endfunction

    // Strobe pattern with at least one byte off
    function automatic logic [3:0] partial_strb();
        logic [3:0] s;
        s = 4'(rand_bits(4));
        return (s == 4'hf) ? 4'h3 : s;
    endfunction

    function automatic logic [31:0] fill_word(input logic [11:0] w);
        return {w, 8'h5a, w ^ 12'hc3a};
    endfunction

    // Exec region is the bottom (size + 1) pages, clamped to the array
    function automatic logic access_allowed(input agent_t ag, input logic [15:0] size,
                                            input logic [11:0] waddr, input logic owner);
        int unsigned end_byte;
        int unsigned byte_addr;
        end_byte = ((32'(size) + 32'd1) << 12) - 32'd1;
        if (end_byte > 32'(mcu_sram_size_bytes - 1)) end_byte = 32'(mcu_sram_size_bytes - 1);
        byte_addr = 32'(waddr) << 2;
        if (byte_addr > end_byte) return ag.mcu_lsu | ag.debug;
        if (owner) return ag.mcu_lsu | ag.mcu_ifu | ag.debug;
        return ag.cptra | ag.debug;
    endfunction

    task automatic check_equal(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            value_errors++;
            $display("FAIL %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("ERROR %0t %s", $time, msg);
    endtask

    task automatic check_idle();
        check_equal("hold", 64'd0, 64'(cif_resp.hold));
        check_equal("error", 64'd0, 64'(cif_resp.error));
        check_equal("sram_cs", 64'd0, 64'(sram_req.cs));
        check_equal("sram_we", 64'd0, 64'(sram_req.we));
    endtask

    task automatic set_controls(input logic lk, input logic mrst);
        @(negedge clk);
        dv = 1'b0;
        lock = lk;
        mcu_rst_b = mrst;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One fabric request, from drive to the end of its last cycle

    task automatic do_access(input agent_t ag, input logic [15:0] size,
                             input logic [11:0] waddr, input logic wr, input logic [3:0] strb,
                             input logic [31:0] wdata, input int nflip);
        logic        allowed;
        logic        two_cycle;
        logic [31:0] merged;
        int          wait_cycles;
        @(negedge clk);
        dv = 1'b1;
        agent = ag;
        fw_size = size;
        cif_req.addr = {18'd0, waddr, 2'b00};
        cif_req.write = wr;
        cif_req.wstrb = strb;
        cif_req.wdata = wdata;
        flip_mask = make_flip(nflip);
        #(clk_period / 4);
        allowed = access_allowed(ag, size, waddr, mcu_owner);
        two_cycle = allowed && (!wr || strb != 4'hf);
        // Cycle 0
        check_equal("error", 64'(!allowed), 64'(cif_resp.error));
        check_equal("hold", 64'(two_cycle), 64'(cif_resp.hold));
        check_equal("sram_cs", 64'(allowed), 64'(sram_req.cs));
        check_equal("sram_we", 64'(allowed && !two_cycle), 64'(sram_req.we));
        check_equal("sram_single_ecc_error", 64'd0, 64'(single_err));
        check_equal("sram_double_ecc_error", 64'd0, 64'(double_err));
        if (allowed) check_equal("sram_addr", 64'(waddr), 64'(sram_req.addr));
        if (allowed && !two_cycle) begin
            check_equal("sram_wdata", 64'(wdata), 64'(sram_req.wdata.data));
            shadow[waddr] = wdata;
        end
        if (two_cycle) begin
            wait_cycles = 0;
            while (cif_resp.hold === 1'b1 && wait_cycles < 4) begin
                @(negedge clk);
                #(clk_period / 4);
                wait_cycles++;
            end
            if (cif_resp.hold !== 1'b0) begin
                report_failure("hold stayed high past the read latency");
            end else begin
                // Data phase
                check_equal("sram_single_ecc_error", 64'(nflip == 1), 64'(single_err));
                check_equal("sram_double_ecc_error", 64'(nflip == 2), 64'(double_err));
                check_equal("error", 64'(nflip == 2), 64'(cif_resp.error));
                if (!wr) begin
                    check_equal("sram_cs", 64'd0, 64'(sram_req.cs));
                    if (nflip < 2) check_equal("rdata", 64'(shadow[waddr]), 64'(cif_resp.rdata));
                end else begin
                    check_equal("rdata", 64'd0, 64'(cif_resp.rdata));
                    // Old word must survive a double error
                    check_equal("sram_we", 64'(nflip < 2), 64'(sram_req.we));
                    if (nflip < 2) begin
                        for (int i = 0; i < 4; i++) begin
                            merged[i*8 +: 8] = strb[i] ? wdata[i*8 +: 8] : shadow[waddr][i*8 +: 8];
                        end
                        check_equal("sram_wdata", 64'(merged), 64'(sram_req.wdata.data));
                        shadow[waddr] = merged;
                    end
                end
            end
        end
    endtask

    task automatic random_traffic(input int n);
        agent_t      ag;
        logic [1:0]  op;
        logic [15:0] size;
        for (int i = 0; i < n; i++) begin
            ag = agent_t'(4'b0001 << rand_bits(2));
            // Half small sizes, half mostly beyond the SRAM
            size = (rand_bits(1) != 0) ? 16'(rand_bits(2)) : 16'(rand_bits(16));
            op = 2'(rand_bits(2));
            do_access(ag, size, 12'(rand_bits(12)), op == 2'd1 || op == 2'd2,
                      (op == 2'd2) ? partial_strb() : 4'hf, rand_bits(32), 0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [11:0] w;
        clk = 1'b0;
        rst_b = 1'b0;
        dv = 1'b0;
        cif_req = '0;
        agent = '0;
        fw_size = '0;
        lock = 1'b0;
        mcu_rst_b = 1'b1;
        flip_mask = '0;
        lfsr_state = 32'hf5a1_34bc;
        checks = 0;
        value_errors = 0;
        other_errors = 0;

        // Quiet outputs through reset and just after
        repeat (reset_cycles) begin
            @(negedge clk);
            #(clk_period / 4);
            check_idle();
        end
        @(negedge clk);
        rst_b = 1'b1;
        #(clk_period / 4);
        check_idle();
        @(negedge clk);
        #(clk_period / 4);
        check_idle();

        // Whole array exec, Caliptra owns it
        for (int i = 0; i < mcu_sram_depth; i++) begin
            do_access(4'b0001, 16'd3, 12'(i), 1'b1, 4'hf, fill_word(12'(i)), 0);
        end
        for (int i = 0; i < n_pairs; i++) begin
            w = 12'(rand_bits(12));
            do_access(4'b0001, 16'd3, w, 1'b1, 4'hf, rand_bits(32), 0);
            do_access(4'b0001, 16'd3, w, 1'b0, 4'hf, 32'd0, 0);
        end
        for (int i = 0; i < n_pairs; i++) begin
            w = 12'(rand_bits(12));
            do_access(4'b0001, 16'd3, w, 1'b1, partial_strb(), rand_bits(32), 0);
            do_access(4'b0001, 16'd3, w, 1'b0, 4'hf, 32'd0, 0);
        end

        // Region rules across the ownership changes
        random_traffic(n_random);
        set_controls(1'b1, 1'b1);
        do_access(4'b0001, 16'd0, 12'd0, 1'b0, 4'hf, 32'd0, 0);
        random_traffic(n_random);
        // Lock off alone keeps the MCU as owner
        set_controls(1'b0, 1'b1);
        do_access(4'b0010, 16'd0, 12'd0, 1'b0, 4'hf, 32'd0, 0);
        random_traffic(n_random);
        set_controls(1'b0, 1'b0);
        set_controls(1'b0, 1'b1);
        do_access(4'b0001, 16'd0, 12'd0, 1'b0, 4'hf, 32'd0, 0);
        random_traffic(n_random);

        // Injected bit flips, debug agent is admitted everywhere
        for (int i = 0; i < n_ecc; i++) begin
            w = 12'(rand_bits(12));
            do_access(4'b1000, 16'd3, w, 1'b0, 4'hf, 32'd0, 1);
            do_access(4'b1000, 16'd3, w, 1'b1, partial_strb(), rand_bits(32), 1);
            do_access(4'b1000, 16'd3, w, 1'b0, 4'hf, 32'd0, 0);
            do_access(4'b1000, 16'd3, w, 1'b0, 4'hf, 32'd0, 2);
            do_access(4'b1000, 16'd3, w, 1'b1, partial_strb(), rand_bits(32), 2);
            do_access(4'b1000, 16'd3, w, 1'b0, 4'hf, 32'd0, 0);
        end

        @(negedge clk);
        dv = 1'b0;
        $display("Checks %0d, value mismatches %0d, other failures %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Four cycles per request slot covers the longest access
    initial begin
        #((total_requests * 4 + reset_cycles) * clk_period);
        $display("Watchdog expired before the test sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* files.f */
hw/mcu_sram_pkg.sv
hw/mcu_sram_ecc_encode.sv
hw/mcu_sram_ecc_decode.sv
hw/mcu_sram_region_filter.sv
hw/mcu_sram_access_seq.sv
hw/mcu_sram_read_resp.sv
hw/mcu_sram_ctrl.sv
dv/tb_mcu_sram_ctrl.sv

/* Makefile */
# Verilator build and run for the MCU SRAM controller testbench

SIM := obj_dir/Vtb_mcu_sram_ctrl

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a listed source changes
$(SIM): files.f $(shell cat files.f)
	verilator --binary --timing --assert --top-module tb_mcu_sram_ctrl \
		-f files.f -o Vtb_mcu_sram_ctrl

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
